/* clb_tile_patterns.txt */
# C <config 72 bits, cell 0 then cell 1> <tile_out during load> <tile_out after commit>
# V <pins a,b,c,d,k> <tile_out x0,y0,x1,y1 after the next rising edge>
# G <largest idle gap between configuration strobes>
# reset configuration, k held low.
V 00 0
V 10 a
V 08 a
V 02 8
V 18 0
V 14 2
V 0A 2
V 04 8
# mode 1 on cell 0, parity on f and majority on g, xor in cell 1.
G 3
C E896472A10FF0002A0 8 a
V 00 0
V 10 a
V 18 0
V 0C 6
V 1C c
V 06 c
V 0A c
V 04 a
# mode 2, b picks the half.
G 0
C E896802A1FF00002A0 a e
V 00 0
V 10 e
V 08 0
V 1C e
V 14 0
V 0E e
V 06 0
V 04 e
# storage bit clocked by k, set from a, reset from d.
C CCCC00020FF00002A0 e a
V 05 f
V 01 5
V 00 5
V 01 0
V 10 0
V 11 4
V 12 4
V 13 0
V 04 a
V 05 f
V 07 f
V 06 f
V 07 b
V 00 1
# toggle through dq1 feedback, cell 1 samples cell 0.
G 2
C 555500AAACC00002A0 1 5
V 01 8
V 00 8
V 05 5
V 04 5
V 05 a
V 04 a

/* build.f */
+incdir+.
clb_pkg.sv
cfg_bit_counter.sv
cfg_loader_fsm.sv
cfg_frame_shifter.sv
clb_cell.sv
clb_tile.sv
tb_clock_gen.sv
tb_clb_tile.sv

/* tb_clb_tile.sv */
`default_nettype none

module tb_clb_tile
   import clb_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam PATTERN_FILE = "clb_tile_patterns.txt";

   logic      KLK;
   logic      rst_n;
   clb_pins_t pins_in;
   logic      cfg_start;
   logic      cfg_bit;
   logic      cfg_bit_valid;
   logic      cfg_busy;
   logic      cfg_done;
   tile_out_t tile_out;

   integer           fd;
   integer           rc;
   integer           seed;
   integer           gap_max;
   integer           num_lines;
   integer           cycle_count = 0;
   integer           cycle_limit = 300;
   logic [8*8-1:0]   tag;
   logic [8*160-1:0] line;
   logic [71:0]      cfg_word;
   logic [4:0]       pins_val;
   logic [3:0]       out_exp;
   logic [3:0]       out_before;
   logic [3:0]       out_after;
   logic             reading;

   tb_clock_gen clk_gen (
      .KLK   (KLK),
      .rst_n (rst_n)
   );

   clb_tile dut0 (
      .KLK           (KLK),
      .rst_n         (rst_n),
      .pins_in       (pins_in),
      .cfg_start     (cfg_start),
      .cfg_bit       (cfg_bit),
      .cfg_bit_valid (cfg_bit_valid),
      .cfg_busy      (cfg_busy),
      .cfg_done      (cfg_done),
      .tile_out      (tile_out)
   );

   task automatic check_value(input string name, input logic [71:0] expected,
                              input logic [71:0] actual);
      if (actual !== expected)
      begin
         $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
         $display("Checks failed");
         $fatal(1, "mismatch on %s.", name);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "run aborted.");
   endtask

   // one cycle of a load, old configuration still driving the cells.
   task automatic check_load_cycle(input logic [3:0] old_out);
      check_value("cfg_busy", 1'b1, cfg_busy);
      check_value("cfg_done", 1'b0, cfg_done);
      check_value("tile_out", old_out, tile_out);
   endtask

   task automatic apply_vector(input logic [4:0] pins, input logic [3:0] expected);
      pins_in = pins;
      @(negedge KLK);
      check_value("tile_out", expected, tile_out);
   endtask

   task automatic load_config(input logic [71:0] word, input logic [3:0] old_out,
                              input logic [3:0] new_out);
      integer i;
      integer n;
      integer gap;
      check_value("cfg_busy", 1'b0, cfg_busy);
      cfg_start = 1'b1;
      @(negedge KLK);
      cfg_start = 1'b0;
      for (i = 71; i >= 0; i = i - 1)
      begin
         gap = $unsigned($random(seed)) % (gap_max + 1);
         for (n = 0; n < gap; n = n + 1)
         begin
            cfg_bit_valid = 1'b0;
            cfg_bit       = ~word[i];   // no strobe, must not be taken.
            check_load_cycle(old_out);
            @(negedge KLK);
         end
         cfg_bit       = word[i];
         cfg_bit_valid = 1'b1;
         check_load_cycle(old_out);
         @(negedge KLK);
         cfg_bit_valid = 1'b0;
      end
      check_load_cycle(old_out);   // commit cycle.
      @(negedge KLK);
      check_value("cfg_done", 1'b1, cfg_done);
      check_value("cfg_busy", 1'b0, cfg_busy);
      check_value("tile_out", new_out, tile_out);
      @(negedge KLK);
      check_value("cfg_done", 1'b0, cfg_done);
   endtask

   always @(posedge KLK)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         abort_run($sformatf("timeout, patterns not finished after %0d cycles.", cycle_limit));
      end
   end

   initial
   begin
      pins_in       = '0;
      cfg_start     = 1'b0;
      cfg_bit       = 1'b0;
      cfg_bit_valid = 1'b0;
      seed          = 32'h2195_ece5;
      gap_max       = 0;
      num_lines     = 0;
      reading       = 1'b1;

      // size the timeout from the pattern count.
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0)
      begin
         abort_run("cannot open the pattern file.");
      end
      while (!$feof(fd))
      begin
         rc = $fgets(line, fd);
         if (rc > 0)
         begin
            num_lines = num_lines + 1;
         end
      end
      $fclose(fd);
      cycle_limit = 20 * num_lines + 300;
      fd = $fopen(PATTERN_FILE, "r");

      @(posedge rst_n);
      @(negedge KLK);
      check_value("cfg_busy", 1'b0, cfg_busy);
      check_value("cfg_done", 1'b0, cfg_done);

      while (reading)
      begin
         rc = $fscanf(fd, "%s", tag);
         if (rc != 1)
         begin
            reading = 1'b0;
         end
         else if (tag == "#")
         begin
            rc = $fgets(line, fd);
         end
         else if (tag == "G")
         begin
            rc = $fscanf(fd, "%d", gap_max);
         end
         else if (tag == "C")
         begin
            rc = $fscanf(fd, "%h %h %h", cfg_word, out_before, out_after);
            if (rc != 3)
            begin
               abort_run("malformed configuration line in the pattern file.");
            end
            load_config(cfg_word, out_before, out_after);
         end
         else if (tag == "V")
         begin
            rc = $fscanf(fd, "%h %h", pins_val, out_exp);
            if (rc != 2)
            begin
               abort_run("malformed vector line in the pattern file.");
            end
            apply_vector(pins_val, out_exp);
         end
         else
         begin
            abort_run("unknown line type in the pattern file.");
         end
      end
      $fclose(fd);
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
(
   output logic KLK,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD = 2;   // 4 ns clock.

   initial
   begin
      KLK   = 1'b0;
      rst_n = 1'b0;
      repeat (2) @(posedge KLK);
      @(negedge KLK);
      rst_n = 1'b1;   // released on a falling edge.
   end

   always #(HALF_PERIOD) KLK = ~KLK;

endmodule

`default_nettype wire

/* clb_tile.sv */
`default_nettype none

module clb_tile
   import clb_pkg::*;
(
   input  wire       KLK,
   input  wire       rst_n,
   input  clb_pins_t pins_in,
   input  wire       cfg_start,
   input  wire       cfg_bit,
   input  wire       cfg_bit_valid,
   output logic      cfg_busy,
   output logic      cfg_done,
   output tile_out_t tile_out
);

   logic      clear_count;
   logic      shift_en;
   logic      commit;
   logic      last_bit;
   clb_cfg_t  cfg0, cfg1;
   clb_pins_t pins1;
   logic      x0, y0, x1, y1;

   cfg_loader_fsm u_loader (
      .KLK           (KLK),
      .rst_n         (rst_n),
      .cfg_start     (cfg_start),
      .cfg_bit_valid (cfg_bit_valid),
      .last_bit      (last_bit),
      .clear_count   (clear_count),
      .shift_en      (shift_en),
      .commit        (commit),
      .cfg_busy      (cfg_busy),
      .cfg_done      (cfg_done)
   );

   // counts exactly the bits that go into the shadow register.
   cfg_bit_counter u_counter (
      .KLK         (KLK),
      .rst_n       (rst_n),
      .clear_count (clear_count),
      .count_en    (shift_en),
      .count       (),
      .last_bit    (last_bit)
   );

   cfg_frame_shifter u_shifter (
      .KLK      (KLK),
      .rst_n    (rst_n),
      .shift_en (shift_en),
      .cfg_bit  (cfg_bit),
      .commit   (commit),
      .cfg0     (cfg0),
      .cfg1     (cfg1)
   );

   clb_cell u_cell0 (
      .KLK   (KLK),
      .rst_n (rst_n),
      .cfg   (cfg0),
      .pins  (pins_in),
      .x     (x0),
      .y     (y0)
   );

   // second cell is fed by the first one's outputs on a and b.
   assign pins1 = '{a: x0, b: y0, c: pins_in.c, d: pins_in.d, k: pins_in.k};

   clb_cell u_cell1 (
      .KLK   (KLK),
      .rst_n (rst_n),
      .cfg   (cfg1),
      .pins  (pins1),
      .x     (x1),
      .y     (y1)
   );

   assign tile_out = '{x0: x0, y0: y0, x1: x1, y1: y1};

endmodule

`default_nettype wire

/* clb_cell.sv */
`default_nettype none

module clb_cell
   import clb_pkg::*;
(
   input  wire       KLK,
   input  wire       rst_n,
   input  clb_cfg_t  cfg,
   input  clb_pins_t pins,
   output logic      x,
   output logic      y
);

   // three way select, last input also taken for code 3.
   function automatic logic pick3(input sel2_t sel, input logic in0, input logic in1,
                                  input logic in2);
      case (sel)
         2'd0:    return in0;
         2'd1:    return in1;
         default: return in2;
      endcase
   endfunction

   logic       a, b, c, d, k;
   logic       dq1, dq2;
   logic [2:0] f_addr, g_addr;
   logic       split_out;
   logic       f, g;
   logic       set_src, rst_src, clk_src;
   logic       clk_src_q;
   logic       clk_edge;
   logic       q, q_next;

   assign a = pins.a;
   assign b = pins.b;
   assign c = pins.c;
   assign d = pins.d;
   assign k = pins.k;

   assign dq1 = cfg.dq_sel[1] ? q : d;
   assign dq2 = cfg.dq_sel[0] ? q : d;

   // mode 1 steering, one select bit per address line.
   assign f_addr = {cfg.f_in_sel[2] ? b : a,
                    cfg.f_in_sel[1] ? c : b,
                    cfg.f_in_sel[0] ? dq1 : c};
   assign g_addr = {cfg.g_in_sel[2] ? b : a,
                    cfg.g_in_sel[1] ? c : b,
                    cfg.g_in_sel[0] ? dq2 : c};

   assign split_out = b ? cfg.lut[{1'b1, a, c, dq2}] : cfg.lut[{1'b0, a, c, dq1}];

   always_comb
   begin
      case (cfg.comb_mode)
         2'd0:
         begin
            f = cfg.lut[{a, b, c, dq1}];
            g = cfg.lut[{a, b, c, dq1}];
         end
         2'd1:
         begin
            f = cfg.lut[{1'b0, f_addr}];   // lower half.
            g = cfg.lut[{1'b1, g_addr}];   // upper half.
         end
         default:
         begin
            f = split_out;
            g = split_out;
         end
      endcase
   end

   assign set_src = pick3(cfg.set_sel, a, f, 1'b0);
   assign rst_src = pick3(cfg.rst_sel, d, g, 1'b0);
   assign clk_src = pick3(cfg.clk_sel, g, c, k);

   assign clk_edge = clk_src & ~clk_src_q;

   // reset source wins over set.
   assign q_next = rst_src ? 1'b0 : (set_src ? 1'b1 : f);

   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         clk_src_q <= 1'b0;
         q         <= 1'b0;
      end
      else
      begin
         clk_src_q <= clk_src;
         if (clk_edge)
         begin
            q <= q_next;
         end
      end
   end

   assign x = pick3(cfg.x_sel, f, g, q);
   assign y = pick3(cfg.y_sel, q, g, f);

   a_q_known : assert property (
      @(posedge KLK) disable iff (!rst_n)
      !$isunknown(q)
   ) else $error("storage bit is unknown.");

endmodule

`default_nettype wire

/* cfg_frame_shifter.sv */
`default_nettype none

`include "clb_macros.svh"

module cfg_frame_shifter
   import clb_pkg::*;
(
   input  wire      KLK,
   input  wire      rst_n,
   input  wire      shift_en,
   input  wire      cfg_bit,
   input  wire      commit,
   output clb_cfg_t cfg0,
   output clb_cfg_t cfg1
);

   localparam clb_cfg_t CFG_DEFAULT = '{
      lut:       `CLB_DEFAULT_LUT,
      comb_mode: `CLB_DEFAULT_MODE,
      f_in_sel:  `CLB_DEFAULT_IN_SEL,
      g_in_sel:  `CLB_DEFAULT_IN_SEL,
      dq_sel:    `CLB_DEFAULT_SEL,
      set_sel:   `CLB_DEFAULT_SRC,
      rst_sel:   `CLB_DEFAULT_SRC,
      clk_sel:   `CLB_DEFAULT_SRC,
      x_sel:     `CLB_DEFAULT_SEL,
      y_sel:     `CLB_DEFAULT_SEL
   };

   cfg_stream_t shadow_q;
   clb_cfg_t    active_q [`CLB_COUNT];

   // bits enter at the lsb, so the first one ends at the top of cell 0.
   always_ff @(posedge KLK)
   begin
      if (shift_en)
      begin
         shadow_q <= {shadow_q[`CLB_STREAM_BITS-2:0], cfg_bit};
      end
   end

   always_ff @(posedge KLK)
   begin
      for (int i = 0; i < `CLB_COUNT; i++)
      begin
         if (!rst_n)
         begin
            active_q[i] <= CFG_DEFAULT;
         end
         else if (commit)
         begin
            active_q[i] <= shadow_q[`CLB_STREAM_BITS-1-i*`CLB_CFG_BITS -: `CLB_CFG_BITS];
         end
      end
   end

   assign cfg0 = active_q[0];
   assign cfg1 = active_q[1];

endmodule

`default_nettype wire

/* cfg_loader_fsm.sv */
`default_nettype none

module cfg_loader_fsm
   import clb_pkg::*;
(
   input  wire  KLK,
   input  wire  rst_n,
   input  wire  cfg_start,
   input  wire  cfg_bit_valid,
   input  wire  last_bit,
   output logic clear_count,
   output logic shift_en,
   output logic commit,
   output logic cfg_busy,
   output logic cfg_done
);

   cfg_state_t state_q;
   cfg_state_t state_d;

   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         state_q <= CFG_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   always_comb
   begin
      state_d     = state_q;
      clear_count = 1'b0;
      shift_en    = 1'b0;
      case (state_q)
         CFG_IDLE:
         begin
            if (cfg_start)
            begin
               clear_count = 1'b1;
               state_d     = CFG_LOAD;
            end
         end
         CFG_LOAD:
         begin
            shift_en = cfg_bit_valid;   // gaps just stretch the load.
            if (cfg_bit_valid && last_bit)
            begin
               state_d = CFG_COMMIT;
            end
         end
         CFG_COMMIT:
         begin
            state_d = CFG_DONE;
         end
         default:
         begin
            state_d = CFG_IDLE;
         end
      endcase
   end

   assign commit   = (state_q == CFG_COMMIT);
   assign cfg_done = (state_q == CFG_DONE);
   assign cfg_busy = (state_q == CFG_LOAD) || (state_q == CFG_COMMIT);

   // done is a single pulse that always follows a commit.
   a_done_pulse : assert property (
      @(posedge KLK) disable iff (!rst_n)
      cfg_done |-> $past(commit) ##1 !cfg_done
   ) else $error("cfg_done is not a single pulse after commit.");

   // a commit only comes right after the last bit was shifted in.
   a_commit_state : assert property (
      @(posedge KLK) disable iff (!rst_n)
      commit |-> (state_q == CFG_COMMIT) && $past(shift_en && last_bit)
   ) else $error("commit outside of the commit state.");

endmodule

`default_nettype wire

/* cfg_bit_counter.sv */
`default_nettype none

`include "clb_macros.svh"

module cfg_bit_counter
   import clb_pkg::*;
(
   input  wire        KLK,
   input  wire        rst_n,
   input  wire        clear_count,
   input  wire        count_en,
   output cfg_count_t count,
   output logic       last_bit
);

   localparam cfg_count_t LAST_POS = cfg_count_t'(`CLB_STREAM_BITS - 1);

   cfg_count_t count_q;

   always_ff @(posedge KLK)
   begin
      if (!rst_n || clear_count)
      begin
         count_q <= '0;
      end
      else if (count_en)
      begin
         count_q <= count_q + 1'b1;
      end
   end

   assign count    = count_q;
   assign last_bit = (count_q == LAST_POS);

   // no bit may be counted once the frame is full.
   a_count_in_frame : assert property (
      @(posedge KLK) disable iff (!rst_n)
      count_en |-> (count_q <= LAST_POS)
   ) else $error("bit counted past the end of the frame.");

endmodule

`default_nettype wire

/* clb_pkg.sv */
`default_nettype none

`include "clb_macros.svh"

package clb_pkg;

   typedef logic [`CLB_COUNT_BITS-1:0]  cfg_count_t;
   typedef logic [`CLB_LUT_BITS-1:0]    lut_t;
   typedef logic [1:0]                  sel2_t;
   typedef logic [2:0]                  in_sel_t;
   typedef logic [`CLB_STREAM_BITS-1:0] cfg_stream_t;

   // one cell's configuration, msb first as it arrives on the serial port.
   typedef struct packed
   {
      lut_t    lut;
      sel2_t   comb_mode;
      in_sel_t f_in_sel;   // a/b, b/c, c/dq1 steering.
      in_sel_t g_in_sel;   // a/b, b/c, c/dq2 steering.
      sel2_t   dq_sel;     // bit 1 for dq1, bit 0 for dq2.
      sel2_t   set_sel;
      sel2_t   rst_sel;
      sel2_t   clk_sel;
      sel2_t   x_sel;
      sel2_t   y_sel;
   } clb_cfg_t;

   typedef struct packed
   {
      logic a;
      logic b;
      logic c;
      logic d;
      logic k;
   } clb_pins_t;

   typedef struct packed
   {
      logic x0;
      logic y0;
      logic x1;
      logic y1;
   } tile_out_t;

   typedef enum logic [1:0]
   {
      CFG_IDLE,
      CFG_LOAD,
      CFG_COMMIT,
      CFG_DONE
   } cfg_state_t;

endpackage

`default_nettype wire

/* clb_macros.svh */
`ifndef CLB_MACROS_SVH
`define CLB_MACROS_SVH

// configuration frame geometry.
`define CLB_CFG_BITS      36
`define CLB_COUNT         2
`define CLB_STREAM_BITS   (`CLB_CFG_BITS * `CLB_COUNT)
`define CLB_COUNT_BITS    7
`define CLB_LUT_BITS      16

// power-up configuration of a cell.
`define CLB_DEFAULT_LUT     16'h0116
`define CLB_DEFAULT_MODE    2'd0
`define CLB_DEFAULT_IN_SEL  3'd0
`define CLB_DEFAULT_SEL     2'd0
`define CLB_DEFAULT_SRC     2'd2   // set, reset and clock sources.

`endif
